/* Bender.yml */
package:
  name: vector_add_unit

dependencies: {}

export_include_dirs:
  - include

sources:
  # Synthesizable unit in compile order
  - include_dirs:
      - include
    files:
      - verilog/vector_unit_pkg.sv
      - verilog/vector_adder.sv
      - verilog/adder_overflow_handler.sv
      - verilog/vector_add_unit.sv

  # Testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/vector_add_unit_tb.sv

/* dv/vector_add_unit_tb.sv */
// Vector add unit testbench

`timescale 1ns/1ps

`include "vector_unit_cfg.svh"

module vector_add_unit_tb import vector_unit_pkg::*; ();

    // Length of each part of the run in clock cycles
    localparam int RESET_CYCLES    = 8;
    localparam int DIRECTED_CYCLES = 40;
    localparam int RANDOM_OPS      = 200;
    localparam int DRAIN_CYCLES    = 8;
    // Every random operation may be preceded by one idle cycle
    localparam int STIM_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + 2 * RANDOM_OPS + DRAIN_CYCLES;
    localparam int MAX_CYCLES  = STIM_CYCLES + 50;

    logic    clk_i = 1'b0;
    logic    reset_i;
    logic    valid_i;
    vector_t a_i;
    vector_t b_i;
    esize_t  element_size_i;
    addop_t  operation_i;
    logic    signed_operation_i;
    logic    clear_i;
    logic    valid_o;
    vector_t result_o;
    logic    overflow_o;
    logic    sat_flag_o;

    // Expected results in issue order
    vector_t exp_res_q[$];
    logic    exp_ovf_q[$];
    string   name_q[$];

    int      value_errs = 0;
    int      protocol_errs = 0;
    int      cycle_count = 0;
    logic    model_flag = 1'b0;
    logic    clear_prev = 1'b0;
    logic    reset_prev = 1'b1;
    logic    [1:0] valid_hist = 2'b00;
    vector_t exp_res;
    logic    exp_ovf;
    string   exp_name;
    // Last finished result, which the outputs hold through idle cycles
    vector_t last_res = '0;
    logic    last_ovf = 1'b0;
    // Set when the result presented this cycle is expected to overflow
    logic    ovf_due = 1'b0;

    vector_add_unit dut (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .valid_i            (valid_i),
        .a_i                (a_i),
        .b_i                (b_i),
        .element_size_i     (element_size_i),
        .operation_i        (operation_i),
        .signed_operation_i (signed_operation_i),
        .clear_i            (clear_i),
        .valid_o            (valid_o),
        .result_o           (result_o),
        .overflow_o         (overflow_o),
        .sat_flag_o         (sat_flag_o)
    );

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Each lane is widened to a full integer, added, then finished
    // Bit 32 of the return value is the overflow flag
    function automatic logic [`VU_DATA_WIDTH:0] ref_add(input vector_t a, input vector_t b,
            input esize_t size, input addop_t op, input logic sgn);
        int     w;
        int     lanes;
        longint mask;
        longint lo;
        longint hi;
        longint ea;
        longint eb;
        longint s;
        longint lane;
        longint acc;
        logic   ovf;
        w     = (size == ESIZE_HALF) ? `VU_HALF_WIDTH : `VU_BYTE_WIDTH;
        lanes = `VU_DATA_WIDTH / w;
        mask  = (longint'(1) << w) - 1;
        lo    = sgn ? -(longint'(1) << (w - 1)) : 0;
        hi    = sgn ? (longint'(1) << (w - 1)) - 1 : mask;
        acc   = 0;
        ovf   = 1'b0;
        for (int i = 0; i < lanes; i++) begin
            ea = (longint'(a) >> (i * w)) & mask;
            eb = (longint'(b) >> (i * w)) & mask;
            // Lanes with the top bit set are negative in signed mode
            if (sgn && ea > hi) ea = ea - (mask + 1);
            if (sgn && eb > hi) eb = eb - (mask + 1);
            s = ea + eb;
            case (op)
                // Arithmetic shift floors the average for negative sums too
                ADD_HALVE: lane = s >>> 1;
                ADD_SAT: begin
                    if (s > hi) begin
                        lane = hi;
                        ovf  = 1'b1;
                    end else if (s < lo) begin
                        lane = lo;
                        ovf  = 1'b1;
                    end else begin
                        lane = s;
                    end
                end
                default: lane = s;
            endcase
            acc = acc | ((lane & mask) << (i * w));
        end
        return {ovf, acc[`VU_DATA_WIDTH-1:0]};
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------

    task automatic issue(input string name, input vector_t a, input vector_t b,
            input esize_t size, input addop_t op, input logic sgn, input logic clr);
        logic [`VU_DATA_WIDTH:0] expected;
        @(negedge clk_i);
        valid_i            = 1'b1;
        a_i                = a;
        b_i                = b;
        element_size_i     = size;
        operation_i        = op;
        signed_operation_i = sgn;
        clear_i            = clr;
        expected = ref_add(a, b, size, op, sgn);
        exp_res_q.push_back(expected[`VU_DATA_WIDTH-1:0]);
        exp_ovf_q.push_back(expected[`VU_DATA_WIDTH]);
        name_q.push_back(name);
    endtask

    task automatic idle(input int cycles, input logic clr);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_i);
            valid_i = 1'b0;
            clear_i = clr;
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------------------

    // Outputs are read at the rising edge, before the edge updates them
    always @(posedge clk_i) begin
        ovf_due = 1'b0;
        if (!reset_prev) begin
            assert (valid_o === valid_hist[1]) else begin
                protocol_errs++;
                $display("Error valid_latency: expected %b, actual %b", valid_hist[1], valid_o);
            end
            if (valid_o && exp_res_q.size() == 0) begin
                protocol_errs++;
                $display("valid_o rose with no operation outstanding");
            end else if (valid_o) begin
                exp_res  = exp_res_q.pop_front();
                exp_ovf  = exp_ovf_q.pop_front();
                exp_name = name_q.pop_front();
                assert (result_o === exp_res && overflow_o === exp_ovf) else begin
                    value_errs++;
                    $display("Error %s: expected %h ovf %b, actual %h ovf %b",
                             exp_name, exp_res, exp_ovf, result_o, overflow_o);
                end
                ovf_due  = exp_ovf;
                last_res = exp_res;
                last_ovf = exp_ovf;
            end else begin
                // Idle cycles keep the last result on the outputs
                assert (result_o === last_res && overflow_o === last_ovf) else begin
                    value_errs++;
                    $display("Error hold: expected %h ovf %b, actual %h ovf %b",
                             last_res, last_ovf, result_o, overflow_o);
                end
            end
        end
        // Sticky flag model, where a new overflow wins over a clear
        if (reset_prev) begin
            model_flag = 1'b0;
        end else if (ovf_due) begin
            model_flag = 1'b1;
        end else if (clear_prev) begin
            model_flag = 1'b0;
        end
        if (!reset_prev) begin
            assert (sat_flag_o === model_flag) else begin
                value_errs++;
                $display("Error sticky_flag: expected %b, actual %b", model_flag, sat_flag_o);
            end
        end
        valid_hist = {valid_hist[0], valid_i};
        clear_prev = clear_i;
        reset_prev = reset_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycle_count, exp_res_q.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(40));
        reset_i            = 1'b1;
        valid_i            = 1'b0;
        a_i                = '0;
        b_i                = '0;
        element_size_i     = ESIZE_BYTE;
        operation_i        = ADD_WRAP;
        signed_operation_i = 1'b0;
        clear_i            = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;

        // Wrapping keeps carries inside their lane
        issue("wrap_byte", 32'h00FF00FF, 32'h00010001, ESIZE_BYTE, ADD_WRAP, 1'b0, 1'b0);
        issue("wrap_half", 32'h00FF00FF, 32'h00010001, ESIZE_HALF, ADD_WRAP, 1'b0, 1'b0);
        issue("wrap_byte_signed", 32'h7F80FF01, 32'h0180FF7F, ESIZE_BYTE, ADD_WRAP, 1'b1, 1'b0);

        // Halving at the operand extremes
        issue("halve_u8_80", 32'h80808080, 32'h80808080, ESIZE_BYTE, ADD_HALVE, 1'b0, 1'b0);
        issue("halve_s8_80", 32'h80808080, 32'h80808080, ESIZE_BYTE, ADD_HALVE, 1'b1, 1'b0);
        issue("halve_u8_ff", 32'hFFFFFFFF, 32'hFFFFFFFF, ESIZE_BYTE, ADD_HALVE, 1'b0, 1'b0);
        issue("halve_s8_ff", 32'hFFFFFFFF, 32'hFFFFFFFF, ESIZE_BYTE, ADD_HALVE, 1'b1, 1'b0);
        issue("halve_u16_ff", 32'hFFFFFFFF, 32'hFFFFFFFF, ESIZE_HALF, ADD_HALVE, 1'b0, 1'b0);
        issue("halve_s16_80", 32'h80008000, 32'h80008000, ESIZE_HALF, ADD_HALVE, 1'b1, 1'b0);
        issue("halve_s8_odd", 32'h01FD05F9, 32'h00000000, ESIZE_BYTE, ADD_HALVE, 1'b1, 1'b0);
        issue("halve_u16_odd", 32'h00030007, 32'h00000000, ESIZE_HALF, ADD_HALVE, 1'b0, 1'b0);

        // Signed saturation next to lanes that pass unchanged
        issue("sat_s8_mixed", 32'h7F7F0010, 32'h01FF80F0, ESIZE_BYTE, ADD_SAT, 1'b1, 1'b0);
        issue("sat_s8_neg", 32'h80808080, 32'h80FF0001, ESIZE_BYTE, ADD_SAT, 1'b1, 1'b0);
        issue("sat_s16_both", 32'h7FFF8000, 32'h00018000, ESIZE_HALF, ADD_SAT, 1'b1, 1'b0);
        issue("sat_s16_mixed", 32'h7FFF0001, 32'h00010001, ESIZE_HALF, ADD_SAT, 1'b1, 1'b0);

        // Unsigned saturation and an exact result
        issue("sat_u8_mixed", 32'hFF01F010, 32'h010120F0, ESIZE_BYTE, ADD_SAT, 1'b0, 1'b0);
        issue("sat_u16_mixed", 32'hFFFF1234, 32'h00011111, ESIZE_HALF, ADD_SAT, 1'b0, 1'b0);
        issue("sat_u8_exact", 32'h10203040, 32'h01020304, ESIZE_BYTE, ADD_SAT, 1'b0, 1'b0);

        // Sticky flag sequence, starting from a clear flag
        idle(1, 1'b1);
        issue("sticky_quiet", 32'h01010101, 32'h01010101, ESIZE_BYTE, ADD_SAT, 1'b0, 1'b0);
        issue("sticky_set", 32'h7F000000, 32'h01000000, ESIZE_BYTE, ADD_SAT, 1'b1, 1'b0);
        issue("sticky_hold0", 32'h00000001, 32'h00000001, ESIZE_BYTE, ADD_WRAP, 1'b0, 1'b0);
        issue("sticky_hold1", 32'h00010000, 32'h00010000, ESIZE_HALF, ADD_SAT, 1'b0, 1'b0);
        idle(2, 1'b0);
        idle(1, 1'b1);
        idle(2, 1'b0);
        // Clear lands on the same edge as the overflowing result
        issue("sticky_race_ovf", 32'h0000FFFF, 32'h00000001, ESIZE_HALF, ADD_SAT, 1'b0, 1'b0);
        issue("sticky_race_clr", 32'h00000000, 32'h00000000, ESIZE_BYTE, ADD_WRAP, 1'b0, 1'b1);
        idle(3, 1'b0);
        idle(1, 1'b1);
        idle(2, 1'b0);

        // Random traffic with occasional gaps and clears
        for (int n = 0; n < RANDOM_OPS; n++) begin
            if ($urandom_range(3, 0) == 0) idle(1, 1'b0);
            issue("random", $urandom(), $urandom(), esize_t'($urandom_range(1, 0)),
                  addop_t'($urandom_range(2, 0)), 1'($urandom_range(1, 0)),
                  $urandom_range(7, 0) == 0);
        end

        idle(1, 1'b0);
        while (exp_res_q.size() != 0) @(negedge clk_i);
        idle(4, 1'b0);

        $display("Errors: %0d value, %0d protocol", value_errs, protocol_errs);
        if (value_errs == 0 && protocol_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : vector_add_unit_tb

/* files.f */
+incdir+include
verilog/vector_unit_pkg.sv
verilog/vector_adder.sv
verilog/adder_overflow_handler.sv
verilog/vector_add_unit.sv
dv/vector_add_unit_tb.sv

/* include/vector_unit_cfg.svh */
// Vector unit configuration

`ifndef VECTOR_UNIT_CFG_SVH
`define VECTOR_UNIT_CFG_SVH

// ---------------------------------------------------------------------------
// Word geometry
// ---------------------------------------------------------------------------

// Width of one packed operand word as seen by the core
`define VU_DATA_WIDTH 32

// ---------------------------------------------------------------------------
// Lane geometry
// ---------------------------------------------------------------------------

// Element width in byte mode
`define VU_BYTE_WIDTH 8

// Element width in half mode
`define VU_HALF_WIDTH 16

// Number of independent lanes in byte mode
`define VU_BYTE_LANES 4

// Number of independent lanes in half mode
`define VU_HALF_LANES 2

// The carry vector always has one bit per byte position
// and half lanes reuse the odd positions for their extended bit

`endif

/* verilog/adder_overflow_handler.sv */
// Vector add result finishing

`timescale 1ns/1ps

`include "vector_unit_cfg.svh"

module adder_overflow_handler import vector_unit_pkg::*; (
    // Lane sums and their extended bits from the adder
    input  vector_t vadd_result_i,
    input  carry_t  carry_i,

    // Lane layout of the word
    input  esize_t  element_size_i,

    // How each lane is finished and whether lanes are signed
    input  addop_t  operation_i,
    input  logic    signed_operation_i,

    // Finished word
    output vector_t result_o,

    // Set when any lane saturated
    output logic    overflow_flag_o
);

    // Clamp values of a signed lane
    localparam byte_t BYTE_POS_MAX = {1'b0, {(`VU_BYTE_WIDTH-1){1'b1}}};
    localparam byte_t BYTE_NEG_MAX = {1'b1, {(`VU_BYTE_WIDTH-1){1'b0}}};
    localparam half_t HALF_POS_MAX = {1'b0, {(`VU_HALF_WIDTH-1){1'b1}}};
    localparam half_t HALF_NEG_MAX = {1'b1, {(`VU_HALF_WIDTH-1){1'b0}}};

    // ---------------------------------------------------------------------------
    // Byte lanes
    // ---------------------------------------------------------------------------

    vector_t byte_halved;
    vector_t byte_saturated;
    logic    byte_overflow;

    always_comb begin : byte_lanes
        byte_t lane;
        byte_t clamp;
        logic  ext;
        logic  lane_ovf;

        byte_halved    = '0;
        byte_saturated = '0;
        byte_overflow  = 1'b0;

        for (int i = 0; i < `VU_BYTE_LANES; i++) begin
            lane = vadd_result_i[i*`VU_BYTE_WIDTH +: `VU_BYTE_WIDTH];
            ext  = carry_i[i];

            // Extended bit on top of the upper lane bits is the extended sum
            // shifted right by one, which floors the average in both modes
            byte_halved[i*`VU_BYTE_WIDTH +: `VU_BYTE_WIDTH] = {ext, lane[`VU_BYTE_WIDTH-1:1]};

            if (signed_operation_i) begin
                // The true sign differs from the stored top bit on overflow
                lane_ovf = ext ^ lane[`VU_BYTE_WIDTH-1];
                clamp    = ext ? BYTE_NEG_MAX : BYTE_POS_MAX;
            end else begin
                // Any carry out means the sum passed the lane maximum
                lane_ovf = ext;
                clamp    = '1;
            end

            byte_saturated[i*`VU_BYTE_WIDTH +: `VU_BYTE_WIDTH] = lane_ovf ? clamp : lane;

            // Every lane contributes to the flag
            byte_overflow = byte_overflow | lane_ovf;
        end
    end : byte_lanes

    // ---------------------------------------------------------------------------
    // Half lanes
    // ---------------------------------------------------------------------------

    vector_t half_halved;
    vector_t half_saturated;
    logic    half_overflow;

    always_comb begin : half_lanes
        half_t lane;
        half_t clamp;
        logic  ext;
        logic  lane_ovf;

        half_halved    = '0;
        half_saturated = '0;
        half_overflow  = 1'b0;

        for (int i = 0; i < `VU_HALF_LANES; i++) begin
            lane = vadd_result_i[i*`VU_HALF_WIDTH +: `VU_HALF_WIDTH];
            // Half lanes keep their extended bit at the upper byte position
            ext  = carry_i[(i+1)*BYTES_PER_HALF-1];

            half_halved[i*`VU_HALF_WIDTH +: `VU_HALF_WIDTH] = {ext, lane[`VU_HALF_WIDTH-1:1]};

            if (signed_operation_i) begin
                lane_ovf = ext ^ lane[`VU_HALF_WIDTH-1];
                clamp    = ext ? HALF_NEG_MAX : HALF_POS_MAX;
            end else begin
                lane_ovf = ext;
                clamp    = '1;
            end

            half_saturated[i*`VU_HALF_WIDTH +: `VU_HALF_WIDTH] = lane_ovf ? clamp : lane;
            half_overflow = half_overflow | lane_ovf;
        end
    end : half_lanes

    // ---------------------------------------------------------------------------
    // Result select
    // ---------------------------------------------------------------------------

    always_comb begin : result_select
        // Wrapping is the fallback and never flags
        result_o        = vadd_result_i;
        overflow_flag_o = 1'b0;

        case (operation_i)
            ADD_WRAP: begin
                result_o = vadd_result_i;
            end
            ADD_HALVE: begin
                result_o = (element_size_i == ESIZE_HALF) ? half_halved : byte_halved;
            end
            ADD_SAT: begin
                if (element_size_i == ESIZE_HALF) begin
                    result_o        = half_saturated;
                    overflow_flag_o = half_overflow;
                end else begin
                    result_o        = byte_saturated;
                    overflow_flag_o = byte_overflow;
                end
            end
            default: begin
                result_o = vadd_result_i;
            end
        endcase
    end : result_select

    // The reserved code would silently fall back to wrapping
    op_legal_a: assert final (operation_i !== 2'd3)
        else $error("adder_overflow_handler: reserved operation code issued");

endmodule : adder_overflow_handler

/* verilog/vector_add_unit.sv */
// Packed SIMD add unit

`timescale 1ns/1ps

module vector_add_unit import vector_unit_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_i,

    // Operation request, accepted on every cycle it is high
    input  logic    valid_i,
    input  vector_t a_i,
    input  vector_t b_i,
    input  esize_t  element_size_i,
    input  addop_t  operation_i,
    input  logic    signed_operation_i,

    // Drops the sticky saturation flag
    input  logic    clear_i,

    // Finished operation
    output logic    valid_o,
    output vector_t result_o,
    output logic    overflow_o,

    // Sticky saturation flag
    output logic    sat_flag_o
);

    // ---------------------------------------------------------------------------
    // Input stage
    // ---------------------------------------------------------------------------

    vector_t a_q;
    vector_t b_q;
    esize_t  es_q;
    addop_t  op_q;
    logic    sgn_q;
    logic    valid_q;

    // Operands are payload and only move when a request arrives
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            a_q <= a_i;
            b_q <= b_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            es_q    <= ESIZE_BYTE;
            op_q    <= ADD_WRAP;
            sgn_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                es_q  <= element_size_i;
                op_q  <= operation_i;
                sgn_q <= signed_operation_i;
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Datapath
    // ---------------------------------------------------------------------------

    vector_t lane_sum;
    carry_t  lane_carry;
    vector_t finished;
    logic    finished_ovf;

    vector_adder u_adder (
        .a_i                (a_q),
        .b_i                (b_q),
        .element_size_i     (es_q),
        .signed_operation_i (sgn_q),
        .sum_o              (lane_sum),
        .carry_o            (lane_carry)
    );

    adder_overflow_handler u_ovf (
        .vadd_result_i      (lane_sum),
        .carry_i            (lane_carry),
        .element_size_i     (es_q),
        .operation_i        (op_q),
        .signed_operation_i (sgn_q),
        .result_o           (finished),
        .overflow_flag_o    (finished_ovf)
    );

    // ---------------------------------------------------------------------------
    // Output stage and sticky flag
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o    <= 1'b0;
            result_o   <= '0;
            overflow_o <= 1'b0;
            sat_flag_o <= 1'b0;
        end else begin
            valid_o <= valid_q;
            // Result and flag hold their last values through idle cycles
            if (valid_q) begin
                result_o   <= finished;
                overflow_o <= finished_ovf;
            end
            // A new overflow beats a clear on the same edge
            if (valid_q && finished_ovf) begin
                sat_flag_o <= 1'b1;
            end else if (clear_i) begin
                sat_flag_o <= 1'b0;
            end
        end
    end

    // A request captured on one edge is presented on the next one
    valid_latency_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (!$past(reset_i, 1) && !$past(reset_i, 2)) |-> (valid_o == $past(valid_i, 2)));

    // A fresh overflow needs a saturating operation and idle cycles only hold it
    ovf_source_a: assert property (@(posedge clk_i) disable iff (reset_i)
        overflow_o |-> (valid_o ? $past(op_q == ADD_SAT) : $stable(overflow_o)));

endmodule : vector_add_unit

/* verilog/vector_adder.sv */
// Lane segmented vector adder

`timescale 1ns/1ps

`include "vector_unit_cfg.svh"

module vector_adder import vector_unit_pkg::*; (
    // Packed operands
    input  vector_t a_i,
    input  vector_t b_i,

    // Lane layout and signedness of the operands
    input  esize_t  element_size_i,
    input  logic    signed_operation_i,

    // Lane sums without their extended bit
    output vector_t sum_o,

    // Extended top bit of each lane sum
    output carry_t  carry_o
);

    // ---------------------------------------------------------------------------
    // Lane boundary map
    // ---------------------------------------------------------------------------

    // A set bit marks a byte segment that closes a lane
    // In byte mode every segment closes a lane
    // In half mode only the top byte of each half does
    carry_t lane_end;

    always_comb begin : lane_boundary
        for (int i = 0; i < `VU_BYTE_LANES; i++) begin
            if (element_size_i == ESIZE_HALF) begin
                lane_end[i] = ((i + 1) % BYTES_PER_HALF) == 0;
            end else begin
                lane_end[i] = 1'b1;
            end
        end
    end : lane_boundary

    // ---------------------------------------------------------------------------
    // Segmented addition
    // ---------------------------------------------------------------------------

    // The word is added one byte segment at a time
    // A segment passes its carry to the next one only when both belong
    // to the same lane, so nothing ever crosses a lane boundary
    always_comb begin : segmented_add
        logic [`VU_BYTE_WIDTH:0] seg_sum;
        logic                    seg_cin;
        logic                    ext_a;
        logic                    ext_b;

        sum_o   = '0;
        carry_o = '0;
        seg_cin = 1'b0;

        for (int i = 0; i < `VU_BYTE_LANES; i++) begin
            // Raw unsigned sum of this segment including the incoming carry
            seg_sum = {1'b0, a_i[i*`VU_BYTE_WIDTH +: `VU_BYTE_WIDTH]}
                    + {1'b0, b_i[i*`VU_BYTE_WIDTH +: `VU_BYTE_WIDTH]}
                    + {{`VU_BYTE_WIDTH{1'b0}}, seg_cin};

            sum_o[i*`VU_BYTE_WIDTH +: `VU_BYTE_WIDTH] = seg_sum[`VU_BYTE_WIDTH-1:0];

            // Extension bits of each operand at this segment
            // Signed lanes replicate the top bit and unsigned lanes pad with zero
            ext_a = signed_operation_i & a_i[(i+1)*`VU_BYTE_WIDTH-1];
            ext_b = signed_operation_i & b_i[(i+1)*`VU_BYTE_WIDTH-1];

            if (lane_end[i]) begin
                // The extended bit is the sum of both extension bits and the
                // raw carry out, taken modulo two
                carry_o[i] = ext_a ^ ext_b ^ seg_sum[`VU_BYTE_WIDTH];
                seg_cin    = 1'b0;
            end else begin
                // Inner byte boundary of a half lane keeps its carry local
                carry_o[i] = 1'b0;
                seg_cin    = seg_sum[`VU_BYTE_WIDTH];
            end
        end
    end : segmented_add

    // ---------------------------------------------------------------------------
    // Checks
    // ---------------------------------------------------------------------------

    // Once real operands are present the lane layout must be known,
    // otherwise every lane boundary above is undefined
    esize_known_a: assert final ($isunknown({a_i, b_i}) || !$isunknown(element_size_i))
        else $error("vector_adder: element size is unknown with valid operands");

endmodule : vector_adder

/* verilog/vector_unit_pkg.sv */
// Vector add unit types

`include "vector_unit_cfg.svh"

package vector_unit_pkg;

    // -----------------------------------------------------------------------
    // Data types
    // -----------------------------------------------------------------------

    // One packed word holding either byte or half lanes
    typedef logic [`VU_DATA_WIDTH-1:0] vector_t;

    // One extended bit per byte position of the word
    // In half mode only the odd positions are meaningful
    typedef logic [`VU_BYTE_LANES-1:0] carry_t;

    // A single byte lane
    typedef logic [`VU_BYTE_WIDTH-1:0] byte_t;

    // A single half lane
    typedef logic [`VU_HALF_WIDTH-1:0] half_t;

    // Number of byte segments that make up one half lane
    localparam int BYTES_PER_HALF = `VU_HALF_WIDTH / `VU_BYTE_WIDTH;

    // -----------------------------------------------------------------------
    // Element size
    // -----------------------------------------------------------------------

    typedef logic esize_t;

    // Four lanes of 8 bits
    localparam esize_t ESIZE_BYTE = 1'b0;
    // Two lanes of 16 bits
    localparam esize_t ESIZE_HALF = 1'b1;

    // -----------------------------------------------------------------------
    // Operation select
    // -----------------------------------------------------------------------

    typedef logic [1:0] addop_t;

    // Plain modular lane sum
    localparam addop_t ADD_WRAP  = 2'd0;
    // Extended lane sum shifted right by one
    localparam addop_t ADD_HALVE = 2'd1;
    // Lane sum clamped to the lane range
    localparam addop_t ADD_SAT   = 2'd2;
    // Code 3 is reserved and must never be issued

endpackage : vector_unit_pkg
